// File: eeprom_rw.f
verilog/eeprom_cmd_pkg.sv
verilog/i2c_bus_pkg.sv
verilog/i2c_bit_tx.sv
verilog/i2c_byte_rx.sv
verilog/eeprom_rw_seq.sv
verilog/eeprom_rw.sv
testbench/eeprom_model.sv
testbench/eeprom_rw_checker.sv
testbench/tb_eeprom_rw.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the eeprom_rw testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_eeprom_rw -f eeprom_rw.f -o tb_eeprom_rw
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_eeprom_rw)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$out"; then
    exit 0
fi
exit 1

// File: testbench/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda_drive_low, // master side
    input  logic no_ack,        // stop acknowledging
    output logic sda_in
);
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_READ} mstate_t;

    logic [7:0] mem [0:2**ADDR_W-1];
    mstate_t    state;
    logic       slave_low;
    logic       sda;
    logic       scl_q;
    logic       sda_q;
    logic [3:0] cnt;      // scl rises in this byte, 9 is the ack clock
    logic [7:0] shreg;
    logic [7:0] rd_byte;
    logic [2:0] blk;
    logic [7:0] ptr;

    assign sda    = ~(sda_drive_low | slave_low); // wired AND of both released lines
    assign sda_in = sda;

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            state     <= M_IDLE;
            slave_low <= 1'b0;
            cnt       <= '0;
            for (int i = 0; i < 2**ADDR_W; i++)
                mem[ADDR_W'(i)] <= 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        end
        else if (scl && scl_q && sda_q && !sda)
        begin
            state     <= M_CTRL; // start or repeated start
            cnt       <= '0;
            slave_low <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            state     <= M_IDLE; // stop
            slave_low <= 1'b0;
        end
        else if (scl && !scl_q)
        begin
            if (cnt < 4'd9)
                cnt <= cnt + 4'd1;
            if (cnt < 4'd8)
                shreg <= {shreg[6:0], sda};
        end
        else if (!scl && scl_q && state != M_IDLE)
        begin
            if (cnt == 4'd8)
            begin
                if (state == M_READ)
                    slave_low <= 1'b0; // master answers the ninth bit
                else if (no_ack || (state == M_CTRL && shreg[7:4] != DEV_TYPE))
                    state <= M_IDLE;
                else
                begin
                    slave_low <= 1'b1;
                    case (state)
                        M_CTRL:  blk <= shreg[3:1];
                        M_ADDR:  ptr <= shreg;
                        M_WDATA: mem[{blk, ptr}] <= shreg;
                        default: ;
                    endcase
                end
            end
            else if (cnt == 4'd9)
            begin
                cnt       <= '0;
                slave_low <= 1'b0;
                case (state)
                    M_CTRL:
                    begin
                        if (shreg[0])
                        begin
                            state     <= M_READ;
                            rd_byte   <= mem[{blk, ptr}];
                            slave_low <= ~mem[{blk, ptr}][7];
                        end
                        else
                            state <= M_ADDR;
                    end
                    M_ADDR:  state <= M_WDATA;
                    M_READ:  state <= M_IDLE;
                    default: ; // single byte writes only
                endcase
            end
            else if (state == M_READ && cnt != 4'd0)
                slave_low <= ~rd_byte[3'd7 - cnt[2:0]]; // msb first
        end
    end

endmodule

`default_nettype wire

// File: testbench/eeprom_rw_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_rw_checker (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              wr,
    input  logic                              rd,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                        wdata,
    input  logic                              busy,
    input  logic                              ack,
    input  eeprom_cmd_pkg::eeprom_rsp_t       rsp,
    input  logic                              scl,
    input  logic                              sda_drive_low,
    input  logic                              exp_nack,
    output int                                n_tests,
    output int                                n_errors
);
    import eeprom_cmd_pkg::*;

    logic [7:0]  shadow [0:2**ADDR_W-1];
    logic        known  [0:2**ADDR_W-1];
    eeprom_req_t req;      // accepted, waiting for ack
    logic        req_nack;
    logic        pending;
    logic        reset_q;

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH test %0d %s got 0x%h expected 0x%h", n_tests, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_idle();
        int errs;
        errs = n_errors;
        compare("busy", 8'(busy), 8'h00);
        compare("ack", 8'(ack), 8'h00);
        compare("sda_drive_low", 8'(sda_drive_low), 8'h00);
        compare("scl", 8'(scl), 8'h01);
        $display("test %0d idle after reset: %s", n_tests, (n_errors == errs) ? "ok" : "FAIL");
        n_tests++;
    endtask

    task automatic finish_test();
        int errs;
        errs = n_errors;
        if (!pending)
        begin
            $display("test %0d: ack seen with no accepted request", n_tests);
            n_errors++;
        end
        else
        begin
            compare("rsp.nack", 8'(rsp.nack), 8'(req_nack));
            if (req.is_read && !req_nack)
            begin
                if (known[req.addr])
                    compare("rsp.rdata", rsp.rdata, shadow[req.addr]);
                else
                begin
                    $display("test %0d: read of address 0x%h that was never written",
                             n_tests, req.addr);
                    n_errors++;
                end
            end
            else if (!req.is_read && !req_nack)
            begin
                shadow[req.addr] = req.wdata;
                known[req.addr]  = 1'b1;
            end
        end
        $display("test %0d %s addr 0x%h: %s", n_tests, req.is_read ? "read" : "write",
                 req.addr, (n_errors == errs) ? "ok" : "FAIL");
        pending = 1'b0;
        n_tests++;
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            reset_q  = 1'b1;
            pending  = 1'b0;
            n_tests  = 0;
            n_errors = 0;
            for (int i = 0; i < 2**ADDR_W; i++)
                known[ADDR_W'(i)] = 1'b0;
        end
        else
        begin
            if (reset_q)
                check_idle();
            reset_q = 1'b0;
            if (!busy && (wr || rd))
            begin
                if (pending)
                begin
                    $display("test %0d: new request accepted before the ack", n_tests);
                    n_errors++;
                end
                pending     = 1'b1;
                req.is_read = !wr; // wr wins
                req.addr    = addr;
                req.wdata   = wdata;
                req_nack    = exp_nack;
            end
            if (ack)
                finish_test();
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_eeprom_rw.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_rw;
    import eeprom_cmd_pkg::*;

    localparam int CLK_DIV  = 4;
    localparam int N_RAND   = 20;
    localparam int READ_CYC = (50 * CLK_DIV + 20) * 2;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_WR_BUSY} op_t;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
        logic              no_ack;   // model switch
        logic              exp_nack;
    } step_t;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              busy;
    logic              ack;
    eeprom_rsp_t       rsp;
    logic              scl;
    logic              sda_drive_low;
    logic              sda_in;
    logic              no_ack;
    logic              exp_nack;
    int                n_tests;
    int                n_errors;
    int                cycles = 0;
    int                max_cyc = 1000;
    integer            seed;
    step_t             steps [$];

    eeprom_rw #(
        .CLK_DIV (CLK_DIV)
    ) eeprom_rw_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .busy          (busy),
        .ack           (ack),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    eeprom_model model_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .no_ack        (no_ack),
        .sda_in        (sda_in)
    );

    eeprom_rw_checker checker_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .busy          (busy),
        .ack           (ack),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .exp_nack      (exp_nack),
        .n_tests       (n_tests),
        .n_errors      (n_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cyc)
        begin
            $display("timeout: run still going after %0d cycles", max_cyc);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic fill_table();
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        steps.push_back('{OP_WR, 11'h055, 8'ha5, 1'b0, 1'b0});
        steps.push_back('{OP_RD, 11'h055, 8'h00, 1'b0, 1'b0});
        // same low byte, different block bits
        steps.push_back('{OP_WR, 11'h155, 8'h3c, 1'b0, 1'b0});
        steps.push_back('{OP_WR, 11'h755, 8'hc3, 1'b0, 1'b0});
        steps.push_back('{OP_RD, 11'h055, 8'h00, 1'b0, 1'b0});
        steps.push_back('{OP_RD, 11'h155, 8'h00, 1'b0, 1'b0});
        steps.push_back('{OP_RD, 11'h755, 8'h00, 1'b0, 1'b0});
        steps.push_back('{OP_WR_BUSY, 11'h055, 8'hff, 1'b0, 1'b0});
        steps.push_back('{OP_RD, 11'h055, 8'h00, 1'b0, 1'b0});
        steps.push_back('{OP_WR, 11'h155, 8'h99, 1'b1, 1'b1}); // slave silent
        steps.push_back('{OP_RD, 11'h155, 8'h00, 1'b1, 1'b1});
        steps.push_back('{OP_RD, 11'h155, 8'h00, 1'b0, 1'b0});
        steps.push_back('{OP_WR, 11'h2aa, 8'h0f, 1'b0, 1'b0});
        steps.push_back('{OP_RD, 11'h2aa, 8'h00, 1'b0, 1'b0});
        for (int i = 0; i < N_RAND; i++)
        begin
            a = ADDR_W'($random(seed));
            d = 8'($random(seed));
            steps.push_back('{OP_WR, a, d, 1'b0, 1'b0});
            steps.push_back('{OP_RD, a, 8'h00, 1'b0, 1'b0});
        end
    endtask

    task automatic run_step(input step_t s);
        @(posedge CLK);
        #1;
        no_ack   = s.no_ack;
        exp_nack = s.exp_nack;
        addr     = s.addr;
        wdata    = s.data;
        wr       = (s.op == OP_WR);
        rd       = (s.op != OP_WR);
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        if (s.op == OP_WR_BUSY)
        begin
            repeat (5) @(posedge CLK);
            #1;
            wr = 1'b1; // lands while busy
            @(posedge CLK);
            #1;
            wr = 1'b0;
        end
        while (ack !== 1'b1)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    initial
    begin
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wdata    = '0;
        no_ack   = 1'b0;
        exp_nack = 1'b0;
        seed     = 32'hddbe_b0fe;
        fill_table();
        max_cyc = steps.size() * READ_CYC + 100;
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;
        foreach (steps[i])
            run_step(steps[i]);
        repeat (4) @(posedge CLK);
        if (n_tests != steps.size() + 1)
            $display("expected %0d tests to finish, saw %0d", steps.size() + 1, n_tests);
        $display("tests %0d, errors %0d", n_tests, n_errors);
        if (n_errors == 0 && n_tests == steps.size() + 1)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/eeprom_cmd_pkg.sv
`default_nettype none

package eeprom_cmd_pkg;

    localparam int ADDR_W = 11; // 2 KB array, top three bits go in the control byte

    // host request, latched on wr or rd
    typedef struct packed {
        logic              is_read;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    // result, valid with ack
    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;   // slave did not acknowledge
    } eeprom_rsp_t;

endpackage

`default_nettype wire

// File: verilog/eeprom_rw.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_rw #(
    parameter int CLK_DIV = 4 // scl half period in CLK cycles
) (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              wr,
    input  logic                              rd,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                        wdata,
    output logic                              busy,
    output logic                              ack,
    output eeprom_cmd_pkg::eeprom_rsp_t       rsp,
    output logic                              scl,
    output logic                              sda_drive_low,
    input  logic                              sda_in
);
    import i2c_bus_pkg::*;

    seg_cmd_t   seg_cmd;
    logic       seg_start;
    logic       seg_done;
    logic       slave_nack;
    logic       rx_start;
    logic       rx_done;
    logic [7:0] rx_byte;

    eeprom_rw_seq seq_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .busy       (busy),
        .ack        (ack),
        .rsp        (rsp),
        .seg_cmd    (seg_cmd),
        .seg_start  (seg_start),
        .seg_done   (seg_done),
        .slave_nack (slave_nack),
        .rx_start   (rx_start),
        .rx_done    (rx_done),
        .rx_byte    (rx_byte)
    );

    i2c_bit_tx #(
        .CLK_DIV (CLK_DIV)
    ) tx_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .seg_cmd       (seg_cmd),
        .seg_start     (seg_start),
        .seg_done      (seg_done),
        .slave_nack    (slave_nack),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    // runs beside tx_i during a receive segment
    i2c_byte_rx rx_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .rx_start (rx_start),
        .scl      (scl),
        .sda_in   (sda_in),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte)
    );

endmodule

`default_nettype wire

// File: verilog/eeprom_rw_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_rw_seq (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              wr,
    input  logic                              rd,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                        wdata,
    output logic                              busy,
    output logic                              ack,
    output eeprom_cmd_pkg::eeprom_rsp_t       rsp,
    output i2c_bus_pkg::seg_cmd_t             seg_cmd,
    output logic                              seg_start,
    input  logic                              seg_done,
    input  logic                              slave_nack,
    output logic                              rx_start,
    input  logic                              rx_done,
    input  logic [7:0]                        rx_byte
);
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_ACK} state_t;

    state_t      state;
    eeprom_req_t req;
    logic [2:0]  step;
    logic [2:0]  last_step;  // index of the stop segment
    logic        nack_q;
    logic        seg_seen;
    logic        rx_seen;
    logic        seg_ok;
    logic        rx_ok;
    logic        step_end;

    assign busy      = (state != ST_IDLE);
    assign ack       = (state == ST_ACK);
    assign seg_start = (state == ST_ISSUE);
    assign rx_start  = seg_start && (seg_cmd.kind == SEG_RECV);
    assign last_step = req.is_read ? 3'd6 : 3'd4;

    // receive finishes only once both blocks report, in either order
    assign seg_ok   = seg_seen | seg_done;
    assign rx_ok    = (seg_cmd.kind != SEG_RECV) | rx_seen | rx_done;
    assign step_end = (state == ST_WAIT) && seg_ok && rx_ok;

    // write: start, ctrl, addr, data, stop
    // read:  start, ctrl, addr, restart, ctrl, recv, stop
    always_comb
    begin
        seg_cmd.kind    = SEG_STOP;
        seg_cmd.tx_byte = 8'h00;
        case (step)
            3'd0: seg_cmd.kind = SEG_START;
            3'd1:
            begin
                seg_cmd.kind    = SEG_SEND;
                seg_cmd.tx_byte = {DEV_TYPE, req.addr[ADDR_W-1:8], 1'b0};
            end
            3'd2:
            begin
                seg_cmd.kind    = SEG_SEND;
                seg_cmd.tx_byte = req.addr[7:0];
            end
            3'd3:
            begin
                seg_cmd.kind    = req.is_read ? SEG_RESTART : SEG_SEND;
                seg_cmd.tx_byte = req.wdata;
            end
            3'd4:
            begin
                if (req.is_read)
                begin
                    seg_cmd.kind    = SEG_SEND;
                    seg_cmd.tx_byte = {DEV_TYPE, req.addr[ADDR_W-1:8], 1'b1};
                end
            end
            3'd5: seg_cmd.kind = SEG_RECV;
            default: seg_cmd.kind = SEG_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            step     <= '0;
            nack_q   <= 1'b0;
            seg_seen <= 1'b0;
            rx_seen  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (wr || rd)
                    begin
                        state  <= ST_ISSUE;
                        step   <= '0;
                        nack_q <= 1'b0;
                    end
                end
                ST_ISSUE: state <= ST_WAIT;
                ST_WAIT:
                begin
                    if (step_end)
                    begin
                        seg_seen <= 1'b0;
                        rx_seen  <= 1'b0;
                        if (step == last_step)
                            state <= ST_ACK;
                        else
                        begin
                            state <= ST_ISSUE;
                            if (seg_cmd.kind == SEG_SEND && slave_nack)
                            begin
                                nack_q <= 1'b1;
                                step   <= last_step; // straight to stop
                            end
                            else
                                step <= step + 3'd1;
                        end
                    end
                    else
                    begin
                        if (seg_done)
                            seg_seen <= 1'b1;
                        if (rx_done)
                            rx_seen <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && (wr || rd))
        begin
            req.is_read <= !wr; // wr wins
            req.addr    <= addr;
            req.wdata   <= wdata;
        end
        if (step_end && step == last_step)
        begin
            rsp.rdata <= (req.is_read && !nack_q) ? rx_byte : 8'h00;
            rsp.nack  <= nack_q;
        end
    end

endmodule

`default_nettype wire

// File: verilog/i2c_bit_tx.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_tx #(
    parameter int CLK_DIV = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  i2c_bus_pkg::seg_cmd_t seg_cmd,
    input  logic                  seg_start,
    output logic                  seg_done,
    output logic                  slave_nack,
    output logic                  scl,
    output logic                  sda_drive_low,
    input  logic                  sda_in
);
    import i2c_bus_pkg::*;

    localparam int CNT_W = $clog2(CLK_DIV);
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] DIV_MID = CNT_W'((CLK_DIV - 1) / 2); // never on DIV_LAST

    logic             active;
    seg_kind_t        kind;
    logic [7:0]       shreg;
    logic [CNT_W-1:0] div_cnt;
    logic [4:0]       half_cnt;   // even halves have scl low, except in a start
    logic [4:0]       half_last;

    assign half_last = (kind == SEG_SEND || kind == SEG_RECV) ? 5'd17 : 5'd1;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active        <= 1'b0;
            kind          <= SEG_STOP;
            div_cnt       <= '0;
            half_cnt      <= '0;
            seg_done      <= 1'b0;
            slave_nack    <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            seg_done <= 1'b0;
            if (active)
            begin
                // sda moves mid-half, well clear of the scl edges
                if (div_cnt == DIV_MID)
                begin
                    case (kind)
                        SEG_START, SEG_RESTART: sda_drive_low <= half_cnt[0];
                        SEG_STOP:               sda_drive_low <= ~half_cnt[0];
                        SEG_SEND:
                        begin
                            if (!half_cnt[0])
                            begin
                                // released on the ninth bit for the slave ack
                                sda_drive_low <= (half_cnt == 5'd16) ? 1'b0 : ~shreg[7];
                                shreg         <= {shreg[6:0], 1'b0};
                            end
                            else if (half_cnt == 5'd17)
                                slave_nack <= sda_in;
                        end
                        default: sda_drive_low <= 1'b0; // receive, master nack on bit 9
                    endcase
                end
                if (div_cnt == DIV_LAST)
                begin
                    div_cnt <= '0;
                    if (half_cnt == half_last)
                    begin
                        active   <= 1'b0;
                        seg_done <= 1'b1;
                    end
                    else
                    begin
                        half_cnt <= half_cnt + 5'd1;
                        scl      <= ~half_cnt[0];
                    end
                end
                else
                    div_cnt <= div_cnt + 1'b1;
            end
            else if (seg_start)
            begin
                active     <= 1'b1;
                kind       <= seg_cmd.kind;
                shreg      <= seg_cmd.tx_byte;
                div_cnt    <= '0;
                half_cnt   <= '0;
                slave_nack <= 1'b0;
                scl        <= (seg_cmd.kind == SEG_START); // bus idle, scl already high
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    localparam logic [3:0] DEV_TYPE = 4'b1010; // serial EEPROM type code

    typedef enum logic [2:0] {
        SEG_START,
        SEG_RESTART,
        SEG_SEND,
        SEG_RECV,
        SEG_STOP
    } seg_kind_t;

    // one bus segment, tx_byte only matters for SEG_SEND
    typedef struct packed {
        seg_kind_t  kind;
        logic [7:0] tx_byte;
    } seg_cmd_t;

endpackage

`default_nettype wire

// File: verilog/i2c_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_rx (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       rx_start,
    input  logic       scl,
    input  logic       sda_in,
    output logic       rx_done,
    output logic [7:0] rx_byte
);
    logic       scl_d;
    logic       scl_rise;
    logic       armed;
    logic [2:0] bit_cnt;

    assign scl_rise = scl & ~scl_d;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_d   <= 1'b1; // scl idles high
            armed   <= 1'b0;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end
        else
        begin
            scl_d   <= scl;
            rx_done <= 1'b0;
            if (rx_start)
            begin
                armed   <= 1'b1;
                bit_cnt <= '0;
            end
            else if (armed && scl_rise)
            begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                begin
                    armed   <= 1'b0; // ninth rise is the master nack, not data
                    rx_done <= 1'b1;
                end
            end
        end
    end

    // msb first
    always_ff @(posedge CLK)
    begin
        if (armed && scl_rise)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

endmodule

`default_nettype wire
